/* mini_core_pkg.sv */
package mini_core_pkg;

    // ========================================
    // widths with a meaning
    // ========================================
    typedef logic [31:0] word_t;      // data and instruction word.
    typedef logic [4:0]  reg_addr_t;  // register index.
    typedef logic [5:0]  opcode_t;    // major opcode, bits 31:26.
    typedef logic [5:0]  funct_t;     // r-type function, bits 5:0.
    typedef logic [3:0]  alu_op_t;

    // ========================================
    // instruction encodings
    // ========================================
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LUI   = 6'h0f;

    localparam funct_t FN_MFHI = 6'h10;
    localparam funct_t FN_MFLO = 6'h12;
    localparam funct_t FN_MULT = 6'h18;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    // internal alu codes, not tied to the isa.
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_SLT  = 4'd4;
    localparam alu_op_t ALU_LUI  = 4'd5;
    localparam alu_op_t ALU_MULT = 4'd6;
    localparam alu_op_t ALU_MFHI = 4'd7;
    localparam alu_op_t ALU_MFLO = 4'd8;

    // apb slave states.
    typedef enum logic {IDLE, ACCESS} apb_state_t;

    // apb address map, register r sits at REG_BASE + 4*r.
    localparam logic [31:0] ISSUE_ADDR = 32'h0000_0000;
    localparam logic [31:0] REG_BASE   = 32'h0000_0080;

endpackage

/* apb_issue_port.sv */
`timescale 1ns/10ps

module apb_issue_port
    import mini_core_pkg::*;
#(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  word_t                 pwdata,
    input  logic                  pipe_busy,
    input  word_t                 rd_data,
    output word_t                 prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  issue_valid,
    output word_t                 issue_insn,
    output reg_addr_t             rd_addr
);

    localparam logic [ADDR_WIDTH-1:0] ISSUE_A  = ADDR_WIDTH'(ISSUE_ADDR);
    localparam logic [ADDR_WIDTH-1:0] REG_A    = ADDR_WIDTH'(REG_BASE);
    localparam logic [ADDR_WIDTH-1:0] REG_SPAN = ADDR_WIDTH'(32 * 4);

    apb_state_t            state;
    apb_state_t            next_state;
    logic [ADDR_WIDTH-1:0] reg_offset;
    logic                  issue_hit;
    logic                  reg_hit;
    logic                  access_phase;
    logic                  read_wait;
    logic                  issue_fire;

    // ========================================
    // address decode
    // ========================================
    assign issue_hit  = (paddr == ISSUE_A);
    assign reg_offset = paddr - REG_A;
    assign reg_hit    = (reg_offset < REG_SPAN) && (paddr[1:0] == 2'b00);
    assign rd_addr    = reg_offset[6:2];  // word index inside the window.

    assign access_phase = (state == ACCESS) && psel && penable;
    assign read_wait    = !pwrite && reg_hit && pipe_busy;  // hold until drained.
    assign issue_fire   = access_phase && pwrite && issue_hit;

    assign pready  = access_phase && !read_wait;
    assign pslverr = pready && (pwrite ? !issue_hit : !reg_hit);
    assign prdata  = (access_phase && !pwrite && reg_hit) ? rd_data : '0;

    // ========================================
    // slave fsm
    // ========================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (psel && !penable) next_state = ACCESS;  // setup phase.
            ACCESS:  if (pready) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            issue_valid <= 1'b0;
        end else begin
            state       <= next_state;
            issue_valid <= issue_fire;  // one cycle per issued word.
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) issue_insn <= pwdata;
    end

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

endmodule

/* reg_file.sv */
`timescale 1ns/10ps

module reg_file
    import mini_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t host_addr,
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     host_data
);

    // r0 has no storage.
    word_t regs [31:1];

    function automatic word_t read_port(reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, two for decode and one for the host.
    assign rs_data   = read_port(rs_addr);
    assign rt_data   = read_port(rt_addr);
    assign host_data = read_port(host_addr);

    // the result stage is expected to drop r0 writes.
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        we |-> (wr_addr != '0));

endmodule

/* insn_decode.sv */
`timescale 1ns/10ps

module insn_decode
    import mini_core_pkg::*;
(
    input  logic      issue_valid,
    input  word_t     issue_insn,
    input  word_t     rs_data,
    input  word_t     rt_data,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output logic      dec_valid,
    output alu_op_t   alu_op,
    output reg_addr_t dest_reg,
    output logic      reg_write,
    output logic      hilo_write,
    output word_t     operand_a,
    output word_t     operand_b
);

    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rd_field;
    logic [15:0] imm;
    word_t       imm_ext;
    word_t       rs_val;
    word_t       rt_val;
    logic        legal;
    logic        rd_dest;
    logic        mult_op;

    // ========================================
    // field split
    // ========================================
    assign opcode   = issue_insn[31:26];
    assign rs_addr  = issue_insn[25:21];
    assign rt_addr  = issue_insn[20:16];
    assign rd_field = issue_insn[15:11];
    assign funct    = issue_insn[5:0];
    assign imm      = issue_insn[15:0];

    always_comb begin
        alu_op  = ALU_ADD;
        legal   = 1'b1;
        rd_dest = 1'b0;
        mult_op = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                rd_dest = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_MFHI: alu_op = ALU_MFHI;
                    FN_MFLO: alu_op = ALU_MFLO;
                    FN_MULT: begin
                        alu_op  = ALU_MULT;
                        mult_op = 1'b1;  // writes hi/lo only.
                    end
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDI: alu_op = ALU_ADD;
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_LUI:  alu_op = ALU_LUI;
            default: legal = 1'b0;  // unknown words become no-ops.
        endcase
    end

    assign dec_valid  = issue_valid;
    assign reg_write  = issue_valid && legal && !mult_op;
    assign hilo_write = issue_valid && legal && mult_op;
    assign dest_reg   = rd_dest ? rd_field : rt_addr;

    // ========================================
    // operands and forwarding
    // ========================================
    assign rs_val = (wb_we && (wb_rd == rs_addr) && (rs_addr != '0)) ? wb_data : rs_data;
    assign rt_val = (wb_we && (wb_rd == rt_addr) && (rt_addr != '0)) ? wb_data : rt_data;

    // only addi sign-extends.
    assign imm_ext = (opcode == OP_ADDI) ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    assign operand_a = rs_val;
    assign operand_b = (opcode == OP_RTYPE) ? rt_val : imm_ext;

endmodule

/* id_ex_stage.sv */
`timescale 1ns/10ps

module id_ex_stage
    import mini_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      dec_valid,
    input  alu_op_t   alu_op,
    input  reg_addr_t dest_reg,
    input  logic      reg_write,
    input  logic      hilo_write,
    input  word_t     operand_a,
    input  word_t     operand_b,
    output logic      ex_valid,
    output alu_op_t   ex_alu_op,
    output reg_addr_t ex_dest_reg,
    output logic      ex_reg_write,
    output logic      ex_hilo_write,
    output word_t     ex_a,
    output word_t     ex_b
);

    // ========================================
    // control fields
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid      <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_hilo_write <= 1'b0;
        end else begin
            ex_valid      <= dec_valid;
            ex_reg_write  <= dec_valid && reg_write;   // bubbles never write.
            ex_hilo_write <= dec_valid && hilo_write;
        end
    end

    // ========================================
    // payload
    // ========================================
    always_ff @(posedge clk) begin
        ex_alu_op   <= alu_op;
        ex_dest_reg <= dest_reg;
        ex_a        <= operand_a;  // already forwarded.
        ex_b        <= operand_b;
    end

endmodule

/* alu_execute.sv */
`timescale 1ns/10ps

module alu_execute
    import mini_core_pkg::*;
(
    input  alu_op_t ex_alu_op,
    input  word_t   ex_a,
    input  word_t   ex_b,
    input  word_t   hi,
    input  word_t   lo,
    output word_t   alu_result,
    output word_t   mult_hi,
    output word_t   mult_lo
);

    logic signed [63:0] product;
    word_t              sum;
    word_t              diff;
    logic               less;

    // ========================================
    // multiplier
    // ========================================
    assign product = $signed(ex_a) * $signed(ex_b);
    assign mult_hi = product[63:32];
    assign mult_lo = product[31:0];

    // ========================================
    // alu
    // ========================================
    assign sum  = ex_a + ex_b;
    assign diff = ex_a - ex_b;
    assign less = ($signed(ex_a) < $signed(ex_b));  // signed compare for slt.

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:  alu_result = sum;
            ALU_SUB:  alu_result = diff;
            ALU_AND:  alu_result = ex_a & ex_b;
            ALU_OR:   alu_result = ex_a | ex_b;
            ALU_SLT:  alu_result = {31'd0, less};
            ALU_LUI:  alu_result = {ex_b[15:0], 16'h0000};
            ALU_MFHI: alu_result = hi;  // current hi/lo from the result stage.
            ALU_MFLO: alu_result = lo;
            ALU_MULT: alu_result = '0;  // product goes to hi/lo.
            default:  alu_result = '0;
        endcase
    end

endmodule

/* result_stage.sv */
`timescale 1ns/10ps

module result_stage
    import mini_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_valid,
    input  reg_addr_t ex_dest_reg,
    input  logic      ex_reg_write,
    input  logic      ex_hilo_write,
    input  word_t     alu_result,
    input  word_t     mult_hi,
    input  word_t     mult_lo,
    output logic      wb_valid,
    output logic      wb_we,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output word_t     hi,
    output word_t     lo
);

    // ========================================
    // ex/wb register and hi/lo
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
            hi       <= '0;
            lo       <= '0;
        end else begin
            wb_valid <= ex_valid;
            wb_we    <= ex_reg_write && (ex_dest_reg != '0);  // r0 stays zero.
            if (ex_valid && ex_hilo_write) begin
                hi <= mult_hi;  // same edge as the mult capture.
                lo <= mult_lo;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_dest_reg;
        wb_data <= alu_result;
    end

    a_we_needs_valid: assert property (@(posedge clk) disable iff (reset)
        wb_we |-> wb_valid);

endmodule

/* mini_core_top.sv */
`timescale 1ns/10ps

module mini_core_top
    import mini_core_pkg::*;
#(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  word_t                 pwdata,
    output word_t                 prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // ========================================
    // interconnect
    // ========================================
    logic      issue_valid;
    word_t     issue_insn;
    logic      pipe_busy;
    reg_addr_t host_addr;
    word_t     host_data;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    logic      dec_valid;
    alu_op_t   alu_op;
    reg_addr_t dest_reg;
    logic      reg_write;
    logic      hilo_write;
    word_t     operand_a;
    word_t     operand_b;

    logic      ex_valid;
    alu_op_t   ex_alu_op;
    reg_addr_t ex_dest_reg;
    logic      ex_reg_write;
    logic      ex_hilo_write;
    word_t     ex_a;
    word_t     ex_b;
    word_t     alu_result;
    word_t     mult_hi;
    word_t     mult_lo;

    logic      wb_valid;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;
    word_t     hi;
    word_t     lo;

    // host reads wait until all three stages are empty.
    assign pipe_busy = issue_valid || ex_valid || wb_valid;

    apb_issue_port #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) apb_i (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .pipe_busy, .rd_data(host_data),
        .prdata, .pready, .pslverr, .issue_valid, .issue_insn,
        .rd_addr(host_addr)
    );

    reg_file rf_i (
        .clk, .reset, .rs_addr, .rt_addr, .host_addr,
        .we(wb_we), .wr_addr(wb_rd), .wr_data(wb_data),
        .rs_data, .rt_data, .host_data
    );

    insn_decode dec_i (
        .issue_valid, .issue_insn, .rs_data, .rt_data, .wb_we, .wb_rd, .wb_data,
        .rs_addr, .rt_addr, .dec_valid, .alu_op, .dest_reg, .reg_write,
        .hilo_write, .operand_a, .operand_b
    );

    id_ex_stage idex_i (
        .clk, .reset, .dec_valid, .alu_op, .dest_reg, .reg_write, .hilo_write,
        .operand_a, .operand_b,
        .ex_valid, .ex_alu_op, .ex_dest_reg, .ex_reg_write, .ex_hilo_write,
        .ex_a, .ex_b
    );

    alu_execute alu_i (
        .ex_alu_op, .ex_a, .ex_b, .hi, .lo,
        .alu_result, .mult_hi, .mult_lo
    );

    result_stage res_i (
        .clk, .reset, .ex_valid, .ex_dest_reg, .ex_reg_write, .ex_hilo_write,
        .alu_result, .mult_hi, .mult_lo,
        .wb_valid, .wb_we, .wb_rd, .wb_data, .hi, .lo
    );

endmodule

/* mini_core_tb.sv */
`timescale 1ns/10ps

module mini_core_tb
    import mini_core_pkg::*;
();

    localparam int ADDR_WIDTH     = 12;
    localparam int N_RAND         = 40;
    localparam int N_CHAIN        = 12;
    // reset reads, random, chain, mult, read after write, error accesses.
    localparam int TOTAL_XFERS    = 32 + (N_RAND + 32) + (N_CHAIN + 32) + 11 + 2 + (4 + 32);
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_XFERS + 100;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;

    word_t exp_rdata;    // expected response of the transfer on the bus.
    logic  exp_err;
    logic  stall_exp;
    int    wait_cycles;

    word_t model_regs [32];
    word_t model_hi;
    word_t model_lo;
    logic  last_issue;
    int    seed;
    int    cycle_count = 0;

    mini_core_top #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) dut_i (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    always #50 clk = ~clk;

    // ========================================
    // failure handling
    // ========================================
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input word_t got, input word_t exp);
        $display("error at %0t: %s is %h, expected %h", $time, sig, got, exp);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%0t: %s", $time, what);
        abort_run();
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_problem($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // ========================================
    // response checks
    // ========================================
    a_prdata: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && pready && !pwrite && !exp_err) |-> (prdata == exp_rdata))
        else report_mismatch("prdata", $sampled(prdata), $sampled(exp_rdata));

    a_pslverr: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && pready) |-> (pslverr == exp_err))
        else report_mismatch("pslverr", 32'($sampled(pslverr)), 32'($sampled(exp_err)));

    a_pready: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !stall_exp) |-> pready)
        else report_mismatch("pready", 32'($sampled(pready)), 32'd1);

    a_read_waits: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && pready && stall_exp) |-> (wait_cycles > 0))
        else report_problem("register read right after an issue finished without a wait state");

    a_bus_quiet: assert property (@(posedge clk) disable iff (reset)
        !(psel && penable) |-> (!pready && !pslverr))
        else report_problem("pready or pslverr high outside an access phase");

    // ========================================
    // encoders and reference model
    // ========================================
    function automatic word_t encode_r(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encode_i(opcode_t op, reg_addr_t rt, reg_addr_t rs,
                                       logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] reg_address(input int r);
        return ADDR_WIDTH'(REG_BASE + 32'(4 * r));
    endfunction

    function automatic void model_exec(input word_t insn);
        opcode_t            op;
        funct_t             fn;
        reg_addr_t          dest;
        word_t              a;
        word_t              b;
        word_t              res;
        logic [15:0]        imm;
        logic               wr;
        logic signed [63:0] prod;
        op   = insn[31:26];
        fn   = insn[5:0];
        imm  = insn[15:0];
        a    = model_regs[insn[25:21]];
        b    = model_regs[insn[20:16]];
        dest = insn[20:16];  // i-type writes rt.
        res  = '0;
        wr   = 1'b1;
        case (op)
            OP_RTYPE: begin
                dest = insn[15:11];
                case (fn)
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    FN_MFHI: res = model_hi;
                    FN_MFLO: res = model_lo;
                    FN_MULT: begin
                        prod     = $signed(a) * $signed(b);
                        model_hi = prod[63:32];
                        model_lo = prod[31:0];
                        wr       = 1'b0;
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDI: res = a + {{16{imm[15]}}, imm};
            OP_ANDI: res = a & {16'h0000, imm};
            OP_ORI:  res = a | {16'h0000, imm};
            OP_LUI:  res = {imm, 16'h0000};
            default: wr = 1'b0;  // no-op.
        endcase
        if (wr && (dest != 5'd0)) begin
            model_regs[dest] = res;
        end
    endfunction

    // ========================================
    // apb stimulus
    // ========================================
    task automatic apb_xfer(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                            input word_t wdata, input word_t exp_data, input logic err);
        paddr       <= addr;  // setup phase.
        psel        <= 1'b1;
        penable     <= 1'b0;
        pwrite      <= wr;
        pwdata      <= wdata;
        exp_rdata   <= exp_data;
        exp_err     <= err;
        stall_exp   <= !wr && !err && last_issue;  // pipeline still busy.
        wait_cycles <= 0;
        last_issue   = wr && (addr == ADDR_WIDTH'(ISSUE_ADDR));
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            wait_cycles <= wait_cycles + 1;
            @(negedge clk);
        end
        @(posedge clk);  // transfer completes on this edge.
    endtask

    task automatic idle_bus();
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic issue(input word_t insn);
        model_exec(insn);
        apb_xfer(1'b1, ADDR_WIDTH'(ISSUE_ADDR), insn, '0, 1'b0);
    endtask

    task automatic read_reg(input int r);
        apb_xfer(1'b0, reg_address(r), '0, model_regs[r], 1'b0);
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < 32; r++) begin
            read_reg(r);
        end
    endtask

    task automatic random_word(output word_t w);
        w = $random(seed);
    endtask

    task automatic pick_random_insn(input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, output word_t insn);
        word_t r;
        int    kind;
        random_word(r);
        kind = int'(r[7:0]) % 9;
        random_word(r);
        case (kind)
            0:       insn = encode_r(FN_ADD, rd, rs, rt);
            1:       insn = encode_r(FN_SUB, rd, rs, rt);
            2:       insn = encode_r(FN_AND, rd, rs, rt);
            3:       insn = encode_r(FN_OR, rd, rs, rt);
            4:       insn = encode_r(FN_SLT, rd, rs, rt);
            5:       insn = encode_i(OP_ADDI, rd, rs, r[15:0]);
            6:       insn = encode_i(OP_ANDI, rd, rs, r[15:0]);
            7:       insn = encode_i(OP_ORI, rd, rs, r[15:0]);
            default: insn = encode_i(OP_LUI, rd, 5'd0, r[15:0]);
        endcase
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        word_t     w;
        word_t     insn;
        word_t     a;
        word_t     b;
        reg_addr_t prev;
        reg_addr_t prev2;
        reg_addr_t rd;
        seed           = 30160;
        reset          = 1'b1;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        exp_rdata      = '0;
        exp_err        = 1'b0;
        stall_exp      = 1'b0;
        wait_cycles    = 0;
        last_issue     = 1'b0;
        model_hi       = '0;
        model_lo       = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        read_all_regs();  // all zero after reset.

        for (int i = 0; i < N_RAND; i++) begin
            random_word(w);
            pick_random_insn(w[4:0], w[9:5], w[14:10], insn);
            issue(insn);
        end
        read_all_regs();

        // each instruction reads the two before it.
        prev  = 5'd7;
        prev2 = 5'd9;
        for (int i = 0; i < N_CHAIN; i++) begin
            random_word(w);
            rd = (w[4:0] == 5'd0) ? 5'd1 : w[4:0];
            pick_random_insn(prev, prev2, rd, insn);
            issue(insn);
            prev2 = prev;
            prev  = rd;
        end
        read_all_regs();

        random_word(a);
        random_word(b);
        a[31] = 1'b1;  // negative multiplicand.
        issue(encode_i(OP_LUI, 5'd1, 5'd0, a[31:16]));
        issue(encode_i(OP_ORI, 5'd1, 5'd1, a[15:0]));
        issue(encode_i(OP_LUI, 5'd2, 5'd0, b[31:16]));
        issue(encode_i(OP_ORI, 5'd2, 5'd2, b[15:0]));
        issue(encode_r(FN_MULT, 5'd0, 5'd1, 5'd2));
        issue(encode_r(FN_MFHI, 5'd3, 5'd0, 5'd0));
        issue(encode_r(FN_MFLO, 5'd4, 5'd0, 5'd0));
        issue(encode_i(OP_ADDI, 5'd0, 5'd1, 16'h1234));
        read_reg(3);
        read_reg(4);
        read_reg(0);

        random_word(w);
        issue(encode_i(OP_ADDI, 5'd5, 5'd5, w[15:0]));
        read_reg(5);  // has to wait for the addi.

        apb_xfer(1'b1, reg_address(6), 32'hdead_beef, '0, 1'b1);
        apb_xfer(1'b0, ADDR_WIDTH'(ISSUE_ADDR), '0, '0, 1'b1);
        apb_xfer(1'b1, 12'h400, 32'h0bad_0bad, '0, 1'b1);
        apb_xfer(1'b0, 12'h300, '0, '0, 1'b1);
        read_all_regs();

        idle_bus();
        repeat (2) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* mini_core_top.f */
mini_core_pkg.sv
apb_issue_port.sv
reg_file.sv
insn_decode.sv
id_ex_stage.sv
alu_execute.sv
result_stage.sv
mini_core_top.sv
mini_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mini_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mini_core_tb -f mini_core_top.f -o mini_core_sim

./obj_dir/mini_core_sim
